// ==== build.f ====
hw/isa_pkg.sv
hw/pipeline_pkg.sv
hw/register_file.sv
hw/hazard_detection_unit.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/pipeline_core.sv
testbench/tb_clock_gen.sv
testbench/pipeline_core_asserts.sv
testbench/pipeline_core_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f build.f --top-module pipeline_core_tb \
		--Mdir obj_dir -o pipeline_core_sim
	./obj_dir/pipeline_core_sim | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== testbench/pipeline_core_tb.sv ====
/*
 * Testbench for the pipeline core
 * Directed stall pairs, x0 checks, random program against an in-order model
 * Retire and stall compare tasks, drain check, cycle timeout, summary
 */
`timescale 1ns/1ps

module pipeline_core_tb;
  import isa_pkg::*;
  import pipeline_pkg::*;

  localparam int NUM_RANDOM  = 300;
  // Random program, two base preloads, three stall pairs, x0 pair
  localparam int TOTAL_INSTR = NUM_RANDOM + 2 + 9 + 2;
  localparam int CYCLE_LIMIT = 6 * TOTAL_INSTR + 50;

  logic        clk;
  logic        rst;
  logic        instr_valid;
  logic [31:0] instr;
  logic        instr_ready;
  logic        retire_valid;
  retire_t     retire;

  int          seed;
  int          errors;
  int          checks;
  int          accepted;
  int          retired;
  int          stall_cycles;
  int          cycle_count;
  string       cur_test;
  logic [31:0] prog [$];
  retire_t     exp_q [$];

  // Architectural state of the reference model
  logic [31:0] mregs [32];
  logic [31:0] mmem [DMEM_WORDS];

  tb_clock_gen tb_clock_gen_i (
    .clk (clk),
    .rst (rst)
  );

  pipeline_core pipeline_core_i (
    .clk          (clk),
    .rst          (rst),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .instr_ready  (instr_ready),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

  // Instruction encoders for the RV32I R, I and S formats
  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  // Reference ALU by funct3 with sub only for register ops with bit 30 set
  function automatic logic [31:0] alu_ref(logic [2:0] f3, logic sub, logic [31:0] a,
                                          logic [31:0] b);
    case (f3)
      3'b000:  return sub ? a - b : a + b;
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b110:  return a | b;
      3'b111:  return a & b;
      default: return a + b;
    endcase
  endfunction

  // Runs one accepted instruction and returns its expected retire record
  function automatic retire_t model_execute(logic [31:0] w);
    retire_t     r;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] byte_addr;
    logic [5:0]  waddr;
    a         = mregs[w[19:15]];
    b         = mregs[w[24:20]];
    imm_i     = {{20{w[31]}}, w[31:20]};
    imm_s     = {{20{w[31]}}, w[31:25], w[11:7]};
    r.opcode    = opcode_e'(w[6:0]);
    r.rd        = w[11:7];
    r.writes_rd = (w[11:7] != 5'd0);
    r.addr      = '0;
    r.value     = '0;
    case (w[6:0])
      7'b0110011: r.value = alu_ref(w[14:12], w[30], a, b);
      7'b0010011: r.value = alu_ref(w[14:12], 1'b0, a, imm_i);
      7'b0000011:
      begin
        byte_addr = a + imm_i;
        waddr     = byte_addr[7:2];
        r.value   = mmem[waddr];
        r.addr    = {26'd0, waddr};
      end
      7'b0100011:
      begin
        // Stores carry no destination
        byte_addr   = a + imm_s;
        waddr       = byte_addr[7:2];
        mmem[waddr] = b;
        r.value     = b;
        r.addr      = {26'd0, waddr};
        r.rd        = '0;
        r.writes_rd = 1'b0;
      end
      default: r.writes_rd = 1'b0;
    endcase
    if (r.writes_rd)
      mregs[r.rd] = r.value;
    return r;
  endfunction

  // Data registers come from x0 to x7
  // x8 and x9 hold the load and store bases
  function automatic logic [31:0] random_instr();
    logic [31:0] r;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  base;
    logic [11:0] offs;
    r    = $random(seed);
    rd   = {2'b00, r[2:0]};
    rs1  = {2'b00, r[5:3]};
    rs2  = {2'b00, r[8:6]};
    base = r[9] ? 5'd9 : 5'd8;
    // Word offset of -16 to 15 keeps both bases inside the memory
    offs = {{5{r[14]}}, r[14:10], 2'b00};
    case (r[23:22])
      2'd0:
      case (r[26:24])
        3'd1:    return enc_r(7'b0100000, rs2, rs1, 3'b000, rd);
        3'd2:    return enc_r(7'd0, rs2, rs1, 3'b111, rd);
        3'd3:    return enc_r(7'd0, rs2, rs1, 3'b110, rd);
        3'd4:    return enc_r(7'd0, rs2, rs1, 3'b100, rd);
        3'd5:    return enc_r(7'd0, rs2, rs1, 3'b010, rd);
        default: return enc_r(7'd0, rs2, rs1, 3'b000, rd);
      endcase
      2'd1:
      case (r[26:24])
        3'd1:    return enc_i(r[31:20], rs1, 3'b111, rd, 7'b0010011);
        3'd2:    return enc_i(r[31:20], rs1, 3'b110, rd, 7'b0010011);
        3'd3:    return enc_i(r[31:20], rs1, 3'b100, rd, 7'b0010011);
        3'd4:    return enc_i(r[31:20], rs1, 3'b010, rd, 7'b0010011);
        default: return enc_i(r[31:20], rs1, 3'b000, rd, 7'b0010011);
      endcase
      2'd2:    return enc_i(offs, base, 3'b010, rd, 7'b0000011);
      default: return enc_s(offs, rs2, base);
    endcase
  endfunction

  // Retire record as readable fields
  function automatic string format_retire(retire_t r);
    return $sformatf("op=%h rd=%0d wr=%b value=%h addr=%h",
                     r.opcode, r.rd, r.writes_rd, r.value, r.addr);
  endfunction

  task automatic check_retire(input retire_t expected, input retire_t actual);
    checks++;
    if (expected !== actual)
    begin
      errors++;
      $display("FAIL %s: expected %s, actual %s",
               cur_test, format_retire(expected), format_retire(actual));
    end
  endtask

  task automatic check_stall(input int expected, input int actual);
    checks++;
    if (expected != actual)
    begin
      errors++;
      $display("FAIL %s: expected %0d stall cycles, actual %0d", cur_test, expected, actual);
    end
  endtask

  // Samples on the falling edge between the driving rising edges
  task automatic watch_outputs();
    forever
    begin
      @(negedge clk);
      if (!rst)
      begin
        if (!instr_ready)
          stall_cycles++;
        if (instr_valid && instr_ready)
        begin
          exp_q.push_back(model_execute(instr));
          accepted++;
        end
        if (retire_valid)
        begin
          retired++;
          if (exp_q.size() == 0)
          begin
            errors++;
            $display("Error in %s: a record retired with no instruction outstanding",
                     cur_test);
          end
          else
            check_retire(exp_q.pop_front(), retire);
        end
      end
    end
  endtask

  // Offers the program in order, optionally with random idle cycles
  task automatic feed_program(input bit gaps);
    int          idx;
    logic [31:0] r;
    idx = 0;
    while (idx < prog.size())
    begin
      @(posedge clk);
      r = $random(seed);
      if (gaps && r[1:0] == 2'b00)
        instr_valid <= 1'b0;
      else
      begin
        instr_valid <= 1'b1;
        instr       <= prog[idx];
      end
      @(negedge clk);
      if (instr_valid && instr_ready)
        idx++;
    end
    @(posedge clk);
    instr_valid <= 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0)
      @(posedge clk);
    repeat (2) @(posedge clk);
  endtask

  task automatic report_test(input int err_before);
    if (errors == err_before)
      $display("Test %s: passed", cur_test);
    else
      $display("Test %s: failed with %0d errors", cur_test, errors - err_before);
  endtask

  // Producer writes x1 and fillers write x6 from x0
  // Consumer reads x1 as both sources
  task automatic run_stall_pair(input string name, input int distance, input int expected);
    int err_before;
    int stall_base;
    cur_test   = name;
    err_before = errors;
    prog.delete();
    prog.push_back(enc_i(12'(10 + distance), 5'd0, 3'b000, 5'd1, 7'b0010011));
    for (int i = 1; i < distance; i++)
      prog.push_back(enc_i(12'(i), 5'd0, 3'b000, 5'd6, 7'b0010011));
    prog.push_back(enc_r(7'd0, 5'd1, 5'd1, 3'b000, 5'd3));
    stall_base = stall_cycles;
    feed_program(1'b0);
    wait_drain();
    check_stall(expected, stall_cycles - stall_base);
    report_test(err_before);
  endtask

  // Write to x0 is dropped and a read of x0 gives zero without a stall
  task automatic run_zero_register();
    int err_before;
    int stall_base;
    cur_test   = "zero_register";
    err_before = errors;
    prog.delete();
    prog.push_back(enc_i(12'd7, 5'd0, 3'b000, 5'd0, 7'b0010011));
    prog.push_back(enc_r(7'd0, 5'd0, 5'd0, 3'b000, 5'd2));
    stall_base = stall_cycles;
    feed_program(1'b0);
    wait_drain();
    check_stall(0, stall_cycles - stall_base);
    report_test(err_before);
  endtask

  task automatic run_random_program();
    int err_before;
    cur_test   = "random_program";
    err_before = errors;
    prog.delete();
    // Base registers at bytes 64 and 128
    prog.push_back(enc_i(12'd64, 5'd0, 3'b000, 5'd8, 7'b0010011));
    prog.push_back(enc_i(12'd128, 5'd0, 3'b000, 5'd9, 7'b0010011));
    for (int i = 0; i < NUM_RANDOM; i++)
      prog.push_back(random_instr());
    feed_program(1'b1);
    wait_drain();
    report_test(err_before);
  endtask

  // Idle pipeline stays silent and every accepted instruction has retired once
  task automatic run_drain_check();
    int err_before;
    int retired_base;
    cur_test     = "drain_and_order";
    err_before   = errors;
    retired_base = retired;
    repeat (20) @(posedge clk);
    checks++;
    if (retired != retired_base)
    begin
      errors++;
      $display("Error in %s: records retired after the program drained", cur_test);
    end
    checks++;
    if (accepted != retired)
    begin
      errors++;
      $display("Error in %s: %0d instructions accepted but %0d retired",
               cur_test, accepted, retired);
    end
    report_test(err_before);
  endtask

  initial
  begin
    seed         = 88323;
    errors       = 0;
    checks       = 0;
    accepted     = 0;
    retired      = 0;
    stall_cycles = 0;
    cur_test     = "reset";
    instr_valid <= 1'b0;
    instr       <= '0;
    for (int i = 0; i < 32; i++)
      mregs[i] = '0;
    for (int i = 0; i < DMEM_WORDS; i++)
      mmem[i] = '0;
    fork
      watch_outputs();
    join_none
    do
      @(posedge clk);
    while (rst);
    run_stall_pair("stall_distance_1", 1, 2);
    run_stall_pair("stall_distance_2", 2, 1);
    run_stall_pair("stall_distance_3", 3, 0);
    run_zero_register();
    run_random_program();
    run_drain_check();
    $display("Summary: %0d checks, %0d errors, %0d instructions retired",
             checks, errors, retired);
    if (errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

  // Cycle budget covers every instruction with full stalls and gaps
  initial
  begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT)
    begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// ==== testbench/pipeline_core_asserts.sv ====
/*
 * Concurrent assertions for the pipeline core
 * Intake handshake, reset behaviour and register write checks
 */
`timescale 1ns/1ps

module pipeline_core_asserts (
  input logic                          clk,
  input logic                          rst,
  input logic                          instr_ready,
  input logic                          retire_valid,
  input logic                          wr_en,
  input logic [isa_pkg::REG_IDX_W-1:0] wr_idx,
  input logic                          dec_valid,
  input isa_pkg::decoded_t             dec
);

  // Decode keeps its instruction while ready is low
  hold_when_not_ready: assert property (@(posedge clk) disable iff (rst)
    !instr_ready |=> (dec_valid && $stable(dec)))
    else $error("instruction accepted while instr_ready was low");

  // Pipeline comes out of reset empty
  empty_after_reset: assert property (@(posedge clk)
    rst |=> !retire_valid)
    else $error("retire_valid high in the cycle after reset");

  // x0 is never a write target
  no_x0_write: assert property (@(posedge clk) disable iff (rst)
    wr_en |-> wr_idx != '0)
    else $error("register write to x0");

  ready_known: assert property (@(posedge clk) disable iff (rst)
    !$isunknown(instr_ready))
    else $error("instr_ready unknown after reset");

endmodule

bind pipeline_core pipeline_core_asserts pipeline_core_asserts_i (
  .clk          (clk),
  .rst          (rst),
  .instr_ready  (instr_ready),
  .retire_valid (retire_valid),
  .wr_en        (wr_en),
  .wr_idx       (wr_idx),
  .dec_valid    (dec_valid),
  .dec          (dec)
);

// ==== testbench/tb_clock_gen.sv ====
/*
 * Testbench clock and reset source
 * 100 ns clock, reset held for five rising edges
 */
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic rst
);

  // Half period of 50 ns
  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Synchronous release on the fifth edge
  initial
  begin
    rst <= 1'b1;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

// ==== hw/pipeline_core.sv ====
/*
 * Four-stage RV32I subset core
 * Decode, execute, memory and writeback with stall-only hazard handling
 */
`timescale 1ns/1ps

module pipeline_core (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  instr_valid,
  input  logic [31:0]           instr,
  output logic                  instr_ready,
  output logic                  retire_valid,
  output pipeline_pkg::retire_t retire
);
  import isa_pkg::*;
  import pipeline_pkg::*;

  // Decode to hazard unit
  decoded_t   dec;
  logic       dec_valid;
  logic       stall;

  // Register file ports
  logic [REG_IDX_W-1:0] rs_idx_a;
  logic [REG_IDX_W-1:0] rs_idx_b;
  logic [XLEN-1:0]      rs_data_a;
  logic [XLEN-1:0]      rs_data_b;
  logic                 wr_en;
  logic [REG_IDX_W-1:0] wr_idx;
  logic [XLEN-1:0]      wr_data;

  // Stage registers and in-flight destinations
  ex_req_t    ex_req;
  mem_req_t   mem_req;
  stage_dst_t ex_dst;
  stage_dst_t mem_dst;

  decode_stage decode_stage_i (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .instr       (instr),
    .stall       (stall),
    .rs_data_a   (rs_data_a),
    .rs_data_b   (rs_data_b),
    .instr_ready (instr_ready),
    .dec         (dec),
    .dec_valid   (dec_valid),
    .rs_idx_a    (rs_idx_a),
    .rs_idx_b    (rs_idx_b),
    .ex_req      (ex_req)
  );

  hazard_detection_unit hazard_detection_unit_i (
    .dec_valid (dec_valid),
    .dec       (dec),
    .ex_dst    (ex_dst),
    .mem_dst   (mem_dst),
    .stall     (stall)
  );

  register_file register_file_i (
    .clk       (clk),
    .rst       (rst),
    .rd_idx_a  (rs_idx_a),
    .rd_idx_b  (rs_idx_b),
    .wr_en     (wr_en),
    .wr_idx    (wr_idx),
    .wr_data   (wr_data),
    .rd_data_a (rs_data_a),
    .rd_data_b (rs_data_b)
  );

  execute_stage execute_stage_i (
    .clk     (clk),
    .rst     (rst),
    .ex_req  (ex_req),
    .ex_dst  (ex_dst),
    .mem_req (mem_req)
  );

  // Writeback lives in the memory stage output register
  memory_stage memory_stage_i (
    .clk          (clk),
    .rst          (rst),
    .mem_req      (mem_req),
    .mem_dst      (mem_dst),
    .wr_en        (wr_en),
    .wr_idx       (wr_idx),
    .wr_data      (wr_data),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

endmodule

// ==== hw/memory_stage.sv ====
/*
 * Memory stage
 * 64-word data memory, word load and store
 * Writeback register driving register write and retire port
 */
`timescale 1ns/1ps

module memory_stage (
  input  logic                          clk,
  input  logic                          rst,
  input  pipeline_pkg::mem_req_t        mem_req,
  output pipeline_pkg::stage_dst_t      mem_dst,
  output logic                          wr_en,
  output logic [isa_pkg::REG_IDX_W-1:0] wr_idx,
  output logic [isa_pkg::XLEN-1:0]      wr_data,
  output logic                          retire_valid,
  output pipeline_pkg::retire_t         retire
);
  import isa_pkg::*;
  import pipeline_pkg::*;

  logic [XLEN-1:0]        dmem [DMEM_WORDS];
  logic [DMEM_ADDR_W-1:0] word_addr;
  logic                   is_load;
  logic                   is_store;
  logic [XLEN-1:0]        load_data;

  assign mem_dst.valid     = mem_req.valid;
  assign mem_dst.writes_rd = mem_req.writes_rd;
  assign mem_dst.rd        = mem_req.rd;

  // Byte address bits 7:2 select the word
  assign word_addr = mem_req.alu_result[DMEM_ADDR_W+1:2];
  assign is_load   = mem_req.valid && mem_req.opcode == OP_LOAD;
  assign is_store  = mem_req.valid && mem_req.opcode == OP_STORE;
  assign load_data = dmem[word_addr];

  // Memory starts out zeroed
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < DMEM_WORDS; i++)
        dmem[i] <= '0;
    end
    else if (is_store)
      dmem[word_addr] <= mem_req.store_data;
  end

  // Writeback record
  always_ff @(posedge clk)
  begin
    if (rst)
      retire_valid <= 1'b0;
    else
    begin
      retire_valid     <= mem_req.valid;
      retire.opcode    <= mem_req.opcode;
      retire.rd        <= mem_req.rd;
      retire.writes_rd <= mem_req.writes_rd;
      retire.value     <= is_load ? load_data :
                          is_store ? mem_req.store_data : mem_req.alu_result;
      retire.addr      <= (is_load || is_store) ? XLEN'(word_addr) : '0;
    end
  end

  assign wr_en   = retire_valid && retire.writes_rd;
  assign wr_idx  = retire.rd;
  assign wr_data = retire.value;

endmodule

// ==== hw/execute_stage.sv ====
/*
 * Execute stage
 * ALU and address adder, execute to memory register
 */
`timescale 1ns/1ps

module execute_stage (
  input  logic                     clk,
  input  logic                     rst,
  input  pipeline_pkg::ex_req_t    ex_req,
  output pipeline_pkg::stage_dst_t ex_dst,
  output pipeline_pkg::mem_req_t   mem_req
);
  import isa_pkg::*;
  import pipeline_pkg::*;

  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] result;

  // Destination seen by the hazard unit
  assign ex_dst.valid     = ex_req.valid;
  assign ex_dst.writes_rd = ex_req.dec.writes_rd;
  assign ex_dst.rd        = ex_req.dec.rd;

  // Immediate replaces rs2 for everything but register ops
  assign op_a = ex_req.rs1_val;
  assign op_b = (ex_req.dec.opcode == OP_REG) ? ex_req.rs2_val : ex_req.dec.imm;

  // Loads and stores arrive with ADD, so this is also the address
  always_comb
  begin
    case (ex_req.dec.alu_op)
      ADD:     result = op_a + op_b;
      SUB:     result = op_a - op_b;
      AND:     result = op_a & op_b;
      OR:      result = op_a | op_b;
      XOR:     result = op_a ^ op_b;
      SLT:     result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      default: result = op_a + op_b;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      mem_req.valid <= 1'b0;
    else
    begin
      mem_req.valid      <= ex_req.valid;
      mem_req.opcode     <= ex_req.dec.opcode;
      mem_req.rd         <= ex_req.dec.rd;
      mem_req.writes_rd  <= ex_req.dec.writes_rd;
      mem_req.alu_result <= result;
      // Store data comes from rs2
      mem_req.store_data <= ex_req.rs2_val;
    end
  end

endmodule

// ==== hw/decode_stage.sv ====
/*
 * Decode stage
 * Instruction holding register with valid/ready intake
 * Field and immediate decode, register read, issue into execute
 */
`timescale 1ns/1ps

module decode_stage (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          instr_valid,
  input  logic [31:0]                   instr,
  input  logic                          stall,
  input  logic [isa_pkg::XLEN-1:0]      rs_data_a,
  input  logic [isa_pkg::XLEN-1:0]      rs_data_b,
  output logic                          instr_ready,
  output isa_pkg::decoded_t             dec,
  output logic                          dec_valid,
  output logic [isa_pkg::REG_IDX_W-1:0] rs_idx_a,
  output logic [isa_pkg::REG_IDX_W-1:0] rs_idx_b,
  output pipeline_pkg::ex_req_t         ex_req
);
  import isa_pkg::*;
  import pipeline_pkg::*;

  logic [31:0] instr_q;
  logic [2:0]  funct3;
  logic        funct7_b5;

  // Room when empty, or when the held instruction leaves this edge
  assign instr_ready = !dec_valid || !stall;

  always_ff @(posedge clk)
  begin
    if (rst)
      dec_valid <= 1'b0;
    else if (instr_ready)
      dec_valid <= instr_valid;
  end

  always_ff @(posedge clk)
  begin
    if (instr_valid && instr_ready)
      instr_q <= instr;
  end

  assign funct3    = instr_q[14:12];
  assign funct7_b5 = instr_q[30];

  always_comb
  begin
    dec.opcode   = opcode_e'(instr_q[6:0]);
    dec.rs1      = instr_q[19:15];
    dec.rs2      = instr_q[24:20];
    dec.rd       = instr_q[11:7];
    dec.uses_rs2 = 1'b0;
    dec.alu_op   = ADD;
    // I-type immediate by default
    dec.imm      = {{(XLEN-12){instr_q[31]}}, instr_q[31:20]};
    case (funct3)
      F3_ADD_SUB: dec.alu_op = (dec.opcode == OP_REG && funct7_b5) ? SUB : ADD;
      F3_SLT:     dec.alu_op = SLT;
      F3_XOR:     dec.alu_op = XOR;
      F3_OR:      dec.alu_op = OR;
      F3_AND:     dec.alu_op = AND;
      default:    dec.alu_op = ADD;
    endcase
    case (dec.opcode)
      OP_REG:   dec.uses_rs2 = 1'b1;
      OP_LOAD:  dec.alu_op   = ADD;
      OP_STORE:
      begin
        // S-type has no destination
        // Its rd bits belong to the offset
        dec.uses_rs2 = 1'b1;
        dec.alu_op   = ADD;
        dec.rd       = '0;
        dec.imm      = {{(XLEN-12){instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
      end
      default:  dec.uses_rs2 = 1'b0;
    endcase
    dec.writes_rd = (dec.opcode == OP_REG || dec.opcode == OP_IMM ||
                     dec.opcode == OP_LOAD) && dec.rd != '0;
  end

  assign rs_idx_a = dec.rs1;
  assign rs_idx_b = dec.rs2;

  // A stall sends a bubble into execute instead of the held instruction
  always_ff @(posedge clk)
  begin
    if (rst || stall)
      ex_req.valid <= 1'b0;
    else
    begin
      ex_req.valid   <= dec_valid;
      ex_req.dec     <= dec;
      ex_req.rs1_val <= rs_data_a;
      ex_req.rs2_val <= rs_data_b;
    end
  end

endmodule

// ==== hw/hazard_detection_unit.sv ====
/*
 * Data hazard detection without forwarding
 * Checks decode sources against execute and memory destinations
 */
`timescale 1ns/1ps

module hazard_detection_unit (
  input  logic                    dec_valid,
  input  isa_pkg::decoded_t       dec,
  input  pipeline_pkg::stage_dst_t ex_dst,
  input  pipeline_pkg::stage_dst_t mem_dst,
  output logic                    stall
);
  import isa_pkg::*;
  import pipeline_pkg::*;

  // True when a source register is produced by the given stage
  function automatic logic dst_hit(stage_dst_t dst, logic [REG_IDX_W-1:0] src);
    dst_hit = dst.valid && dst.writes_rd && src != '0 && dst.rd == src;
  endfunction

  logic rs1_hit;
  logic rs2_hit;

  // rs1 is read by every kept instruction
  // Both younger stages are checked together so neither can mask the other
  always_comb
  begin
    rs1_hit = dst_hit(ex_dst, dec.rs1) || dst_hit(mem_dst, dec.rs1);
    rs2_hit = 1'b0;
    // rs2 only matters for register ALU ops and stores
    if (dec.uses_rs2)
      rs2_hit = dst_hit(ex_dst, dec.rs2) || dst_hit(mem_dst, dec.rs2);
  end

  // Writeback producers need no stall since the register file bypasses them
  assign stall = dec_valid && (rs1_hit || rs2_hit);

endmodule

// ==== hw/register_file.sv ====
/*
 * Integer register file, 32 x 32 bit
 * Two read ports, one write port, x0 hardwired to zero
 * Write data bypassed to reads of the same index
 */
`timescale 1ns/1ps

module register_file (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [isa_pkg::REG_IDX_W-1:0] rd_idx_a,
  input  logic [isa_pkg::REG_IDX_W-1:0] rd_idx_b,
  input  logic                          wr_en,
  input  logic [isa_pkg::REG_IDX_W-1:0] wr_idx,
  input  logic [isa_pkg::XLEN-1:0]      wr_data,
  output logic [isa_pkg::XLEN-1:0]      rd_data_a,
  output logic [isa_pkg::XLEN-1:0]      rd_data_b
);
  import isa_pkg::*;

  logic [XLEN-1:0] regs [NUM_REGS];

  // Writes to x0 are dropped
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < NUM_REGS; i++)
        regs[i] <= '0;
    end
    else if (wr_en && wr_idx != '0)
      regs[wr_idx] <= wr_data;
  end

  // Writeback value wins over the stored one on both read ports
  always_comb
  begin
    rd_data_a = regs[rd_idx_a];
    rd_data_b = regs[rd_idx_b];
    if (wr_en && wr_idx == rd_idx_a)
      rd_data_a = wr_data;
    if (wr_en && wr_idx == rd_idx_b)
      rd_data_b = wr_data;
    // x0 always reads zero
    if (rd_idx_a == '0)
      rd_data_a = '0;
    if (rd_idx_b == '0)
      rd_data_b = '0;
  end

endmodule

// ==== hw/pipeline_pkg.sv ====
/*
 * Pipeline structures
 * Data memory depth, stage registers, hazard destination, retire record
 */
package pipeline_pkg;

  // Data memory is word organised
  localparam int DMEM_WORDS  = 64;
  localparam int DMEM_ADDR_W = $clog2(DMEM_WORDS);

  // Decode to execute register
  typedef struct packed {
    logic                      valid;
    isa_pkg::decoded_t         dec;
    logic [isa_pkg::XLEN-1:0]  rs1_val;
    logic [isa_pkg::XLEN-1:0]  rs2_val;
  } ex_req_t;

  // Execute to memory register
  typedef struct packed {
    logic                          valid;
    isa_pkg::opcode_e              opcode;
    logic [isa_pkg::REG_IDX_W-1:0] rd;
    logic                          writes_rd;
    // ALU result, or byte address for load and store
    logic [isa_pkg::XLEN-1:0]      alu_result;
    logic [isa_pkg::XLEN-1:0]      store_data;
  } mem_req_t;

  // Completed instruction as seen on the retire port
  typedef struct packed {
    isa_pkg::opcode_e              opcode;
    logic [isa_pkg::REG_IDX_W-1:0] rd;
    logic                          writes_rd;
    logic [isa_pkg::XLEN-1:0]      value;
    logic [isa_pkg::XLEN-1:0]      addr;
  } retire_t;

  // Destination of an instruction in flight, for hazard checks
  typedef struct packed {
    logic                          valid;
    logic                          writes_rd;
    logic [isa_pkg::REG_IDX_W-1:0] rd;
  } stage_dst_t;

endpackage

// ==== hw/isa_pkg.sv ====
/*
 * RV32I subset definitions
 * Data and register index widths, funct3 codes
 * Opcode and ALU operation enums, decoded instruction struct
 */
package isa_pkg;

  // Data path and register file geometry
  localparam int XLEN      = 32;
  localparam int REG_IDX_W = 5;
  localparam int NUM_REGS  = 32;

  // funct3 codes shared by OP and OP-IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // Major opcodes kept in this core
  typedef enum logic [6:0] {
    OP_REG   = 7'b0110011,
    OP_IMM   = 7'b0010011,
    OP_LOAD  = 7'b0000011,
    OP_STORE = 7'b0100011
  } opcode_e;

  typedef enum logic [2:0] {
    ADD, SUB, AND, OR, XOR, SLT
  } alu_op_e;

  // One instruction after decode
  typedef struct packed {
    opcode_e                opcode;
    alu_op_e                alu_op;
    logic [REG_IDX_W-1:0]   rs1;
    logic [REG_IDX_W-1:0]   rs2;
    logic [REG_IDX_W-1:0]   rd;
    logic [XLEN-1:0]        imm;
    logic                   uses_rs2;
    logic                   writes_rd;
  } decoded_t;

endpackage
